// ==== Makefile ====
TOP := tb_axi_master_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then \
		echo "simulation ended without a pass line"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== sim/axi_master_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_master_sva
    import axi_pkg::*;
(
    input wire       aclk,
    input wire       areset_n,
    input wire       ar_valid_i,
    input wire       ar_ready_i,
    input axi_addr_t ar_addr_i,
    input axi_len_t  ar_len_i,
    input wire       aw_valid_i,
    input wire       aw_ready_i,
    input axi_addr_t aw_addr_i,
    input axi_len_t  aw_len_i,
    input wire       w_valid_i,
    input wire       w_ready_i,
    input axi_data_t w_data_i,
    input axi_strb_t w_strb_i,
    input wire       w_last_i,
    input wire       r_ready_i,
    input wire       b_ready_i,
    input wire       ifu_r_ready_i,
    input wire       lsu_r_ready_i,
    input wire       lsu_w_ready_i
);

    axi_len_t w_cnt_q;
    axi_len_t w_len_q;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            w_cnt_q <= '0;
            w_len_q <= '0;
        end else if (aw_valid_i && aw_ready_i) begin
            w_cnt_q <= '0;
            w_len_q <= aw_len_i;
        end else if (w_valid_i && w_ready_i) begin
            w_cnt_q <= w_cnt_q + 8'd1;  // counts accepted W beats of the burst
        end
    end

    ar_hold: assert property (@(posedge aclk) disable iff (areset_n)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i) && $stable(ar_len_i))
        else $error("AR changed or dropped before ar_ready");

    aw_hold: assert property (@(posedge aclk) disable iff (areset_n)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i) && $stable(aw_len_i))
        else $error("AW changed or dropped before aw_ready");

    w_hold: assert property (@(posedge aclk) disable iff (areset_n)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_strb_i)
        && $stable(w_last_i))
        else $error("W beat changed or dropped before w_ready");

    w_last_beat: assert property (@(posedge aclk) disable iff (areset_n)
        w_valid_i |-> (w_last_i == (w_cnt_q == w_len_q)))
        else $error("w_last does not mark beat len+1");

    // the first reset edge clears the state, after that everything must be quiet
    quiet_in_reset: assert property (@(posedge aclk)
        areset_n && $past(areset_n) |-> !(ar_valid_i || aw_valid_i || w_valid_i || r_ready_i
        || b_ready_i || ifu_r_ready_i || lsu_r_ready_i || lsu_w_ready_i))
        else $error("control output high during reset");

endmodule

bind axi_master_top axi_master_sva u_sva (
    .aclk          (aclk),
    .areset_n      (areset_n),
    .ar_valid_i    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .ar_addr_i     (ar_addr_o),
    .ar_len_i      (ar_len_o),
    .aw_valid_i    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .aw_addr_i     (aw_addr_o),
    .aw_len_i      (aw_len_o),
    .w_valid_i     (w_valid_o),
    .w_ready_i     (w_ready_i),
    .w_data_i      (w_data_o),
    .w_strb_i      (w_strb_o),
    .w_last_i      (w_last_o),
    .r_ready_i     (r_ready_o),
    .b_ready_i     (b_ready_o),
    .ifu_r_ready_i (ifu_r_ready_o),
    .lsu_r_ready_i (lsu_r_ready_o),
    .lsu_w_ready_i (lsu_w_ready_o)
);

`default_nettype wire

// ==== sim/tb_axi_master_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_master_top
    import axi_pkg::*, core_bus_pkg::*;
();

    localparam int TEST_BEATS     = 200;  // 28 + 2 + 8 + 2 + 40 ops of up to 4 beats
    localparam int MAX_STALL      = 16;
    localparam int TIMEOUT_CYCLES = 2 * TEST_BEATS * MAX_STALL;

    logic       aclk          = 1'b0;
    logic       areset_n      = 1'b1;
    logic       ifu_r_valid_i = 1'b0;
    core_addr_t ifu_r_addr_i  = '0;
    axi_size_t  ifu_r_size_i  = '0;
    axi_len_t   ifu_r_len_i   = '0;
    logic       lsu_r_valid_i = 1'b0;
    core_addr_t lsu_r_addr_i  = '0;
    axi_size_t  lsu_r_size_i  = '0;
    axi_len_t   lsu_r_len_i   = '0;
    logic       lsu_w_valid_i = 1'b0;
    core_addr_t lsu_w_addr_i  = '0;
    axi_size_t  lsu_w_size_i  = '0;
    axi_len_t   lsu_w_len_i   = '0;
    core_word_t lsu_w_data_i  = '0;
    logic       ar_ready_i    = 1'b0;
    logic       r_valid_i     = 1'b0;
    axi_data_t  r_data_i      = '0;
    axi_resp_t  r_resp_i      = '0;
    logic       r_last_i      = 1'b0;
    axi_id_t    r_id_i        = '0;
    logic       aw_ready_i    = 1'b0;
    logic       w_ready_i     = 1'b0;
    logic       b_valid_i     = 1'b0;
    axi_resp_t  b_resp_i      = '0;
    axi_id_t    b_id_i        = '0;

    logic       ifu_r_ready_o;
    core_word_t ifu_r_data_o;
    logic       ifu_r_last_o;
    logic       lsu_r_ready_o;
    core_word_t lsu_r_data_o;
    logic       lsu_r_last_o;
    logic       lsu_w_ready_o;
    logic       lsu_w_last_o;
    logic       ar_valid_o;
    axi_addr_t  ar_addr_o;
    axi_id_t    ar_id_o;
    axi_len_t   ar_len_o;
    axi_size_t  ar_size_o;
    axi_burst_t ar_burst_o;
    logic       r_ready_o;
    logic       aw_valid_o;
    axi_addr_t  aw_addr_o;
    axi_id_t    aw_id_o;
    axi_len_t   aw_len_o;
    axi_size_t  aw_size_o;
    axi_burst_t aw_burst_o;
    logic       w_valid_o;
    axi_data_t  w_data_o;
    axi_strb_t  w_strb_o;
    logic       w_last_o;
    logic       b_ready_o;

    axi_data_t   mem [0:255];      // slave model storage
    logic [7:0]  ref_mem [0:2047]; // expected bytes, updated by the write rule
    core_word_t  wr_words [0:3];
    int          done_cycle [0:1];
    int          cycle_cnt   = 0;
    logic        stall_en    = 1'b0;
    logic [31:0] stall_lfsr  = 32'hf80a;
    logic [31:0] stim_lfsr   = 32'hf80a;
    logic        rd_busy     = 1'b0;
    axi_addr_t   rd_addr     = '0;
    axi_len_t    rd_len      = '0;
    axi_size_t   rd_size     = '0;
    axi_len_t    rd_cnt      = '0;
    axi_id_t     rd_id       = '0;
    logic        wr_busy     = 1'b0;
    axi_addr_t   wr_addr     = '0;
    axi_size_t   wr_size     = '0;
    axi_id_t     wr_id       = '0;
    logic        b_pending   = 1'b0;

    axi_master_top #(
        .RD_ID      (4'd0),
        .WR_ID      (4'd1),
        .FETCH_PRIO (1'b0)
    ) dut (.*);

    initial begin
        forever #10 aclk = ~aclk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    function automatic logic stall_go();
        if (!stall_en) begin
            return 1'b1;
        end
        stall_lfsr = lfsr_step(stall_lfsr);
        return stall_lfsr[0];
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'b10110};
    endfunction

    function automatic axi_addr_t beat_bytes(input axi_size_t size);
        return axi_addr_t'(1) << size;
    endfunction

    // bytes from the address up to the end of its 8-byte word, zeros past it
    function automatic core_word_t expect_read(input core_addr_t a);
        core_word_t w;
        int         i;
        w = '0;
        for (i = 0; i < 4; i++) begin
            if (int'(a[2:0]) + i < 8) begin
                w[8*i +: 8] = ref_mem[a[10:0] + 11'(i)];
            end
        end
        return w;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    always @(posedge aclk) begin : slave_model
        int w;
        int b;
        if (areset_n) begin
            for (w = 0; w < 2048; w++) begin
                mem[w[10:3]][{w[2:0], 3'b000} +: 8] <= fill_byte(w[10:0]);
            end
            ar_ready_i <= 1'b0;
            r_valid_i  <= 1'b0;
            r_last_i   <= 1'b0;
            aw_ready_i <= 1'b0;
            w_ready_i  <= 1'b0;
            b_valid_i  <= 1'b0;
            rd_busy    <= 1'b0;
            wr_busy    <= 1'b0;
            b_pending  <= 1'b0;
        end else begin
            if (ar_valid_o && ar_ready_i) begin
                check_eq("ar_burst_o", 64'(ar_burst_o), 64'(AXI_BURST_INCR));
                rd_busy    <= 1'b1;
                rd_addr    <= ar_addr_o;
                rd_len     <= ar_len_o;
                rd_size    <= ar_size_o;
                rd_cnt     <= '0;
                rd_id      <= ar_id_o;
                ar_ready_i <= 1'b0;
            end else begin
                ar_ready_i <= !rd_busy && stall_go();
            end
            if (r_valid_i && r_ready_o) begin
                r_valid_i <= 1'b0;
                r_last_i  <= 1'b0;
                if (rd_cnt == rd_len) begin
                    rd_busy <= 1'b0;
                end else begin
                    rd_cnt  <= rd_cnt + 8'd1;
                    rd_addr <= rd_addr + beat_bytes(rd_size);  // INCR, beats aligned to size
                end
            end else if (rd_busy && !r_valid_i && stall_go()) begin
                r_valid_i <= 1'b1;
                r_data_i  <= mem[rd_addr[10:3]];
                r_last_i  <= (rd_cnt == rd_len);
                r_id_i    <= rd_id;
            end
            if (aw_valid_o && aw_ready_i) begin
                check_eq("aw_burst_o", 64'(aw_burst_o), 64'(AXI_BURST_INCR));
                wr_busy    <= 1'b1;
                wr_addr    <= aw_addr_o;
                wr_size    <= aw_size_o;
                wr_id      <= aw_id_o;
                aw_ready_i <= 1'b0;
            end else begin
                aw_ready_i <= !wr_busy && stall_go();
            end
            if (w_valid_o && w_ready_i) begin
                for (b = 0; b < 8; b++) begin
                    if (w_strb_o[b]) begin
                        mem[wr_addr[10:3]][8*b +: 8] <= w_data_o[8*b +: 8];
                    end
                end
                wr_addr <= wr_addr + beat_bytes(wr_size);
                if (w_last_o) begin
                    b_pending <= 1'b1;
                    w_ready_i <= 1'b0;
                end else begin
                    w_ready_i <= stall_go();
                end
            end else begin
                w_ready_i <= wr_busy && !b_pending && !b_valid_i && stall_go();
            end
            if (b_valid_i && b_ready_o) begin
                b_valid_i <= 1'b0;
                wr_busy   <= 1'b0;
            end else if (b_pending && stall_go()) begin
                b_valid_i <= 1'b1;
                b_resp_i  <= AXI_RESP_OKAY;
                b_id_i    <= wr_id;
                b_pending <= 1'b0;
            end
        end
    end

    task automatic write_op(input core_addr_t addr, input axi_size_t size, input axi_len_t len);
        int         beat;
        int         i;
        core_addr_t a;
        beat = 0;
        @(posedge aclk);
        lsu_w_valid_i <= 1'b1;
        lsu_w_addr_i  <= addr;
        lsu_w_size_i  <= size;
        lsu_w_len_i   <= len;
        lsu_w_data_i  <= wr_words[0];
        while (beat <= int'(len)) begin
            @(posedge aclk);
            check_eq("lsu_w_last_o", 64'(lsu_w_last_o),
                64'(lsu_w_ready_o && (beat == int'(len))));
            if (lsu_w_ready_o) begin
                a = addr + core_addr_t'(beat << size);
                for (i = 0; i < (1 << size); i++) begin
                    ref_mem[a[10:0] + 11'(i)] = wr_words[beat[1:0]][8*i +: 8];
                end
                beat++;
                if (beat <= int'(len)) begin
                    lsu_w_data_i <= wr_words[beat[1:0]];  // next word once the beat is taken
                end else begin
                    lsu_w_valid_i <= 1'b0;
                end
            end
        end
    endtask

    task automatic read_op(input logic fetch, input core_addr_t addr, input axi_size_t size,
                           input axi_len_t len);
        int         beat;
        logic       rdy;
        logic       lst;
        logic       other_rdy;
        core_word_t dat;
        core_addr_t a;
        beat = 0;
        @(posedge aclk);
        if (fetch) begin
            ifu_r_valid_i <= 1'b1;
            ifu_r_addr_i  <= addr;
            ifu_r_size_i  <= size;
            ifu_r_len_i   <= len;
        end else begin
            lsu_r_valid_i <= 1'b1;
            lsu_r_addr_i  <= addr;
            lsu_r_size_i  <= size;
            lsu_r_len_i   <= len;
        end
        while (beat <= int'(len)) begin
            @(posedge aclk);
            rdy       = fetch ? ifu_r_ready_o : lsu_r_ready_o;
            lst       = fetch ? ifu_r_last_o : lsu_r_last_o;
            dat       = fetch ? ifu_r_data_o : lsu_r_data_o;
            other_rdy = fetch ? lsu_r_ready_o : ifu_r_ready_o;
            check_eq(fetch ? "ifu_r_last_o" : "lsu_r_last_o", 64'(lst),
                64'(rdy && (beat == int'(len))));
            if (rdy) begin
                check_eq(fetch ? "lsu_r_ready_o" : "ifu_r_ready_o", 64'(other_rdy), 64'd0);
                a = addr + core_addr_t'(beat << size);
                check_eq(fetch ? "ifu_r_data_o" : "lsu_r_data_o", 64'(dat), 64'(expect_read(a)));
                beat++;
                if (beat > int'(len)) begin
                    if (fetch) begin
                        ifu_r_valid_i <= 1'b0;
                    end else begin
                        lsu_r_valid_i <= 1'b0;
                    end
                end
            end
        end
        done_cycle[fetch] = cycle_cnt;
    endtask

    task automatic test_single_writes();
        int         s;
        int         off;
        core_addr_t a;
        for (s = 0; s < 3; s++) begin
            for (off = 0; off < 8; off += (1 << s)) begin
                a = 32'h100 + core_addr_t'(off);
                wr_words[0] = stim_bits(32);
                write_op(a, axi_size_t'(s), 8'd0);
                read_op(1'b0, a & ~32'h3, AXI_SIZE_4, 8'd0);  // old bytes around the new ones
            end
        end
    endtask

    task automatic test_port_reads();
        read_op(1'b0, 32'h203, AXI_SIZE_1, 8'd0);
        read_op(1'b1, 32'h304, AXI_SIZE_4, 8'd0);
    endtask

    task automatic test_burst();
        int i;
        for (i = 0; i < 4; i++) begin
            wr_words[i] = stim_bits(32);
        end
        write_op(32'h180, AXI_SIZE_4, 8'd3);
        read_op(1'b0, 32'h180, AXI_SIZE_4, 8'd3);
    endtask

    task automatic test_same_cycle();
        fork
            read_op(1'b0, 32'h048, AXI_SIZE_4, 8'd0);
            read_op(1'b1, 32'h084, AXI_SIZE_4, 8'd0);
        join
        check_eq("lsu_done_first", 64'(done_cycle[0] < done_cycle[1]), 64'd1);
    endtask

    task automatic test_random_stalls();
        int         n;
        int         i;
        logic [1:0] op;
        axi_size_t  size;
        axi_len_t   len;
        core_addr_t addr;
        @(posedge aclk);
        stall_en <= 1'b1;
        for (n = 0; n < 40; n++) begin
            op   = 2'(stim_bits(2));
            size = axi_size_t'(stim_bits(2) % 3);
            len  = axi_len_t'(stim_bits(2));
            addr = stim_bits(11) & ~((32'd1 << size) - 32'd1);
            if (op == 2'd1) begin
                read_op(1'b0, addr, size, len);
            end else if (op == 2'd2) begin
                read_op(1'b1, addr, size, len);
            end else begin
                for (i = 0; i < 4; i++) begin
                    wr_words[i] = stim_bits(32);
                end
                write_op(addr, size, len);
            end
        end
    endtask

    initial begin : main
        int i;
        for (i = 0; i < 2048; i++) begin
            ref_mem[i] = fill_byte(11'(i));
        end
        repeat (5) @(posedge aclk);
        areset_n <= 1'b0;
        $display("single writes at every offset");
        test_single_writes();
        $display("reads from both ports");
        test_port_reads();
        $display("burst write and read");
        test_burst();
        $display("same-cycle fetch and load/store reads");
        test_same_cycle();
        $display("mixed operations with random stalls");
        test_random_stalls();
        repeat (4) @(posedge aclk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/axi_master_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_master_top
    import axi_pkg::*, core_bus_pkg::*;
#(
    parameter axi_id_t RD_ID      = 4'd0,
    parameter axi_id_t WR_ID      = 4'd1,
    parameter bit      FETCH_PRIO = 1'b0
) (
    input  wire        aclk,
    input  wire        areset_n,
    input  wire        ifu_r_valid_i,
    input  core_addr_t ifu_r_addr_i,
    input  axi_size_t  ifu_r_size_i,
    input  axi_len_t   ifu_r_len_i,
    output logic       ifu_r_ready_o,
    output core_word_t ifu_r_data_o,
    output logic       ifu_r_last_o,
    input  wire        lsu_r_valid_i,
    input  core_addr_t lsu_r_addr_i,
    input  axi_size_t  lsu_r_size_i,
    input  axi_len_t   lsu_r_len_i,
    output logic       lsu_r_ready_o,
    output core_word_t lsu_r_data_o,
    output logic       lsu_r_last_o,
    input  wire        lsu_w_valid_i,
    input  core_addr_t lsu_w_addr_i,
    input  axi_size_t  lsu_w_size_i,
    input  axi_len_t   lsu_w_len_i,
    input  core_word_t lsu_w_data_i,
    output logic       lsu_w_ready_o,
    output logic       lsu_w_last_o,
    output logic       ar_valid_o,
    output axi_addr_t  ar_addr_o,
    output axi_id_t    ar_id_o,
    output axi_len_t   ar_len_o,
    output axi_size_t  ar_size_o,
    output axi_burst_t ar_burst_o,
    input  wire        ar_ready_i,
    output logic       r_ready_o,
    input  wire        r_valid_i,
    input  axi_data_t  r_data_i,
    input  axi_resp_t  r_resp_i,
    input  wire        r_last_i,
    input  axi_id_t    r_id_i,
    output logic       aw_valid_o,
    output axi_addr_t  aw_addr_o,
    output axi_id_t    aw_id_o,
    output axi_len_t   aw_len_o,
    output axi_size_t  aw_size_o,
    output axi_burst_t aw_burst_o,
    input  wire        aw_ready_i,
    output logic       w_valid_o,
    output axi_data_t  w_data_o,
    output axi_strb_t  w_strb_o,
    output logic       w_last_o,
    input  wire        w_ready_i,
    output logic       b_ready_o,
    input  wire        b_valid_i,
    input  axi_resp_t  b_resp_i,
    input  axi_id_t    b_id_i
);

    mem_rd_if ifu_rd ();
    mem_rd_if lsu_rd ();
    mem_rd_if bus_rd ();  // arbiter to read master
    mem_wr_if lsu_wr ();

    assign ifu_rd.valid  = ifu_r_valid_i;
    assign ifu_rd.addr   = ifu_r_addr_i;
    assign ifu_rd.size   = ifu_r_size_i;
    assign ifu_rd.len    = ifu_r_len_i;
    assign ifu_r_ready_o = ifu_rd.ready;
    assign ifu_r_data_o  = ifu_rd.data;
    assign ifu_r_last_o  = ifu_rd.last;

    assign lsu_rd.valid  = lsu_r_valid_i;
    assign lsu_rd.addr   = lsu_r_addr_i;
    assign lsu_rd.size   = lsu_r_size_i;
    assign lsu_rd.len    = lsu_r_len_i;
    assign lsu_r_ready_o = lsu_rd.ready;
    assign lsu_r_data_o  = lsu_rd.data;
    assign lsu_r_last_o  = lsu_rd.last;

    assign lsu_wr.valid  = lsu_w_valid_i;
    assign lsu_wr.addr   = lsu_w_addr_i;
    assign lsu_wr.size   = lsu_w_size_i;
    assign lsu_wr.len    = lsu_w_len_i;
    assign lsu_wr.data   = lsu_w_data_i;
    assign lsu_w_ready_o = lsu_wr.ready;
    assign lsu_w_last_o  = lsu_wr.last;

    rd_port_arbiter #(
        .FETCH_PRIO (FETCH_PRIO)
    ) u_rd_arb (
        .aclk     (aclk),
        .areset_n (areset_n),
        .fetch_i  (ifu_rd.responder),
        .lsu_i    (lsu_rd.responder),
        .bus_o    (bus_rd.requester)
    );

    axi_rd_master #(
        .RD_ID (RD_ID)
    ) u_rd_master (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .req_i      (bus_rd.responder),
        .ar_valid_o (ar_valid_o),
        .ar_addr_o  (ar_addr_o),
        .ar_id_o    (ar_id_o),
        .ar_len_o   (ar_len_o),
        .ar_size_o  (ar_size_o),
        .ar_burst_o (ar_burst_o),
        .ar_ready_i (ar_ready_i),
        .r_ready_o  (r_ready_o),
        .r_valid_i  (r_valid_i),
        .r_data_i   (r_data_i),
        .r_resp_i   (r_resp_i),
        .r_last_i   (r_last_i),
        .r_id_i     (r_id_i)
    );

    axi_wr_master #(
        .WR_ID (WR_ID)
    ) u_wr_master (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .req_i      (lsu_wr.responder),
        .aw_valid_o (aw_valid_o),
        .aw_addr_o  (aw_addr_o),
        .aw_id_o    (aw_id_o),
        .aw_len_o   (aw_len_o),
        .aw_size_o  (aw_size_o),
        .aw_burst_o (aw_burst_o),
        .aw_ready_i (aw_ready_i),
        .w_valid_o  (w_valid_o),
        .w_data_o   (w_data_o),
        .w_strb_o   (w_strb_o),
        .w_last_o   (w_last_o),
        .w_ready_i  (w_ready_i),
        .b_ready_o  (b_ready_o),
        .b_valid_i  (b_valid_i),
        .b_resp_i   (b_resp_i),
        .b_id_i     (b_id_i)
    );

endmodule

`default_nettype wire

// ==== source/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 64;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam int AXI_ID_W   = 4;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [7:0]            axi_len_t;   // beats minus one
    typedef logic [2:0]            axi_size_t;
    typedef logic [1:0]            axi_burst_t;
    typedef logic [1:0]            axi_resp_t;
    typedef logic [AXI_ID_W-1:0]   axi_id_t;

    localparam axi_size_t AXI_SIZE_1 = 3'b000;
    localparam axi_size_t AXI_SIZE_2 = 3'b001;
    localparam axi_size_t AXI_SIZE_4 = 3'b010;

    localparam axi_burst_t AXI_BURST_INCR = 2'b01;

    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    // low address bits that pick a byte lane of the 64-bit bus
    localparam int AXI_LANE_BITS = 3;

endpackage

`default_nettype wire

// ==== source/axi_rd_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_master
    import axi_pkg::*, core_bus_pkg::*;
#(
    parameter axi_id_t RD_ID = 4'd0
) (
    input  wire         aclk,
    input  wire         areset_n,
    mem_rd_if.responder req_i,
    output logic        ar_valid_o,
    output axi_addr_t   ar_addr_o,
    output axi_id_t     ar_id_o,
    output axi_len_t    ar_len_o,
    output axi_size_t   ar_size_o,
    output axi_burst_t  ar_burst_o,
    input  wire         ar_ready_i,
    output logic        r_ready_o,
    input  wire         r_valid_i,
    input  axi_data_t   r_data_i,
    input  axi_resp_t   r_resp_i,
    input  wire         r_last_i,
    input  axi_id_t     r_id_i
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } rd_state_e;

    rd_state_e                state_q;
    core_addr_t               addr_q;
    axi_size_t                size_q;
    axi_len_t                 len_q;
    logic [AXI_LANE_BITS-1:0] lane_q;
    logic [AXI_LANE_BITS-1:0] lane_step;
    logic                     r_beat;
    axi_data_t                r_shifted;

    assign ar_valid_o = (state_q == ADDR);
    assign ar_addr_o  = axi_addr_t'(addr_q);
    assign ar_id_o    = RD_ID;
    assign ar_len_o   = len_q;
    assign ar_size_o  = size_q;
    assign ar_burst_o = AXI_BURST_INCR;
    assign r_ready_o  = (state_q == DATA);

    assign r_beat    = r_ready_o && r_valid_i && (r_id_i == RD_ID);
    assign lane_step = AXI_LANE_BITS'(1) << size_q;
    assign r_shifted = r_data_i >> {lane_q, 3'b000};

    assign req_i.ready = r_beat;
    assign req_i.last  = r_beat && r_last_i;
    // slverr and decerr both set bit 1, the core gets zeros instead of bus garbage
    assign req_i.data  = r_resp_i[1] ? '0 : core_word_t'(r_shifted);

    always_ff @(posedge aclk) begin
        if (state_q == IDLE && req_i.valid) begin
            addr_q <= req_i.addr;
            size_q <= req_i.size;
            len_q  <= req_i.len;
            lane_q <= req_i.addr[AXI_LANE_BITS-1:0];
        end else if (r_beat) begin
            lane_q <= lane_q + lane_step;  // wraps at the 8-byte word
        end
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (req_i.valid) state_q <= ADDR;
                ADDR: if (ar_ready_i) state_q <= DATA;
                DATA: if (r_beat && r_last_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/axi_wr_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_wr_master
    import axi_pkg::*, core_bus_pkg::*;
#(
    parameter axi_id_t WR_ID = 4'd1
) (
    input  wire         aclk,
    input  wire         areset_n,
    mem_wr_if.responder req_i,
    output logic        aw_valid_o,
    output axi_addr_t   aw_addr_o,
    output axi_id_t     aw_id_o,
    output axi_len_t    aw_len_o,
    output axi_size_t   aw_size_o,
    output axi_burst_t  aw_burst_o,
    input  wire         aw_ready_i,
    output logic        w_valid_o,
    output axi_data_t   w_data_o,
    output axi_strb_t   w_strb_o,
    output logic        w_last_o,
    input  wire         w_ready_i,
    output logic        b_ready_o,
    input  wire         b_valid_i,
    input  axi_resp_t   b_resp_i,
    input  axi_id_t     b_id_i
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } wr_state_e;

    wr_state_e                state_q;
    core_addr_t               addr_q;
    axi_size_t                size_q;
    axi_len_t                 len_q;
    axi_len_t                 cnt_q;
    logic [AXI_LANE_BITS-1:0] lane_q;
    logic [AXI_LANE_BITS-1:0] lane_step;
    axi_strb_t                strb_base;
    logic                     w_beat;
    logic                     b_done;

    assign aw_valid_o = (state_q == ADDR);
    assign aw_addr_o  = axi_addr_t'(addr_q);
    assign aw_id_o    = WR_ID;
    assign aw_len_o   = len_q;
    assign aw_size_o  = size_q;
    assign aw_burst_o = AXI_BURST_INCR;

    always_comb begin
        case (size_q)
            AXI_SIZE_1: strb_base = 8'h01;
            AXI_SIZE_2: strb_base = 8'h03;
            AXI_SIZE_4: strb_base = 8'h0f;
            default:    strb_base = 8'h00;  // wider sizes are not issued by the core
        endcase
    end

    assign w_valid_o = (state_q == DATA);
    assign w_data_o  = axi_data_t'(req_i.data) << {lane_q, 3'b000};
    assign w_strb_o  = strb_base << lane_q;
    assign w_last_o  = w_valid_o && (cnt_q == len_q);
    // the slave may answer as soon as the last W beat lands
    assign b_ready_o = (state_q == DATA) || (state_q == RESP);

    assign w_beat    = w_valid_o && w_ready_i;
    // error responses close the transaction like OKAY does
    assign b_done    = b_ready_o && b_valid_i && (b_id_i == WR_ID);
    assign lane_step = AXI_LANE_BITS'(1) << size_q;

    assign req_i.ready = w_beat;
    assign req_i.last  = w_beat && w_last_o;

    always_ff @(posedge aclk) begin
        if (state_q == IDLE && req_i.valid) begin
            addr_q <= req_i.addr;
            size_q <= req_i.size;
            len_q  <= req_i.len;
            lane_q <= req_i.addr[AXI_LANE_BITS-1:0];
        end else if (w_beat) begin
            lane_q <= lane_q + lane_step;
        end
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (req_i.valid) state_q <= ADDR;
                end
                ADDR: if (aw_ready_i) state_q <= DATA;
                DATA: begin
                    if (w_beat) begin
                        cnt_q <= cnt_q + 8'd1;
                        if (w_last_o) state_q <= RESP;
                    end
                end
                RESP: if (b_done) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/core_bus_pkg.sv ====
`default_nettype none

package core_bus_pkg;

    localparam int CORE_XLEN = 32;

    typedef logic [CORE_XLEN-1:0] core_addr_t;
    typedef logic [CORE_XLEN-1:0] core_word_t;

endpackage

`default_nettype wire

// ==== source/mem_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if
    import axi_pkg::*, core_bus_pkg::*;
();

    logic       valid;
    core_addr_t addr;
    axi_size_t  size;
    axi_len_t   len;
    logic       ready;  // qualifies each returned beat
    core_word_t data;
    logic       last;

    modport requester (
        output valid, addr, size, len,
        input  ready, data, last
    );

    modport responder (
        input  valid, addr, size, len,
        output ready, data, last
    );

endinterface

`default_nettype wire

// ==== source/mem_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_wr_if
    import axi_pkg::*, core_bus_pkg::*;
();

    logic       valid;
    core_addr_t addr;
    axi_size_t  size;
    axi_len_t   len;
    core_word_t data;   // requester moves to the next word after each ready
    logic       ready;
    logic       last;

    modport requester (
        output valid, addr, size, len, data,
        input  ready, last
    );

    modport responder (
        input  valid, addr, size, len, data,
        output ready, last
    );

endinterface

`default_nettype wire

// ==== source/rd_port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_port_arbiter #(
    parameter bit FETCH_PRIO = 1'b0
) (
    input  wire         aclk,
    input  wire         areset_n,
    mem_rd_if.responder fetch_i,
    mem_rd_if.responder lsu_i,
    mem_rd_if.requester bus_o
);

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_LSU,
        GNT_FETCH
    } grant_e;

    grant_e grant_q;
    logic   pick_fetch;
    logic   sel_fetch;

    // a fetch wins when alone, or on a tie if fetch has priority
    assign pick_fetch = fetch_i.valid && (!lsu_i.valid || FETCH_PRIO);

    // while idle the choice is combinational so the master sees it at once
    assign sel_fetch = (grant_q == GNT_IDLE) ? pick_fetch : (grant_q == GNT_FETCH);

    always_comb begin
        bus_o.valid = sel_fetch ? fetch_i.valid : lsu_i.valid;
        bus_o.addr  = sel_fetch ? fetch_i.addr  : lsu_i.addr;
        bus_o.size  = sel_fetch ? fetch_i.size  : lsu_i.size;
        bus_o.len   = sel_fetch ? fetch_i.len   : lsu_i.len;
    end

    always_comb begin
        fetch_i.ready = sel_fetch && bus_o.ready;
        fetch_i.last  = sel_fetch && bus_o.last;
        fetch_i.data  = sel_fetch ? bus_o.data : '0;
        lsu_i.ready   = !sel_fetch && bus_o.ready;
        lsu_i.last    = !sel_fetch && bus_o.last;
        lsu_i.data    = sel_fetch ? '0 : bus_o.data;
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            grant_q <= GNT_IDLE;
        end else begin
            case (grant_q)
                GNT_IDLE: begin
                    if (fetch_i.valid || lsu_i.valid) begin
                        grant_q <= pick_fetch ? GNT_FETCH : GNT_LSU;
                    end
                end
                GNT_LSU, GNT_FETCH: begin
                    if (bus_o.ready && bus_o.last) begin
                        grant_q <= GNT_IDLE;  // released once the final beat is taken
                    end
                end
                default: begin
                    grant_q <= GNT_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/axi_pkg.sv
source/core_bus_pkg.sv
source/mem_rd_if.sv
source/mem_wr_if.sv
source/rd_port_arbiter.sv
source/axi_rd_master.sv
source/axi_wr_master.sv
source/axi_master_top.sv
sim/axi_master_sva.sv
sim/tb_axi_master_top.sv
